// ==== design/serial_alu_defs.svh ====
// word, nibble and apb address widths plus the register offsets of the serial alu
`ifndef SERIAL_ALU_DEFS_SVH
`define SERIAL_ALU_DEFS_SVH

// operand and result width
`define WORD_W 32

// one alu step works on a single nibble
`define NIB_W 4
`define NIB_CNT 8
`define NIB_IDX_W 3

// apb address width
`define APB_AW 5

// register offsets
`define REG_OP_A 5'h00
`define REG_OP_B 5'h04
`define REG_CTRL 5'h08
`define REG_STATUS 5'h0C
`define REG_RESULT 5'h10

`endif

// ==== design/alu_types_pkg.sv ====
// data word, nibble, nibble index and command types of the alu datapath
`default_nettype none

`include "serial_alu_defs.svh"

package alu_types_pkg;

    // full operand or result word
    typedef logic [`WORD_W-1:0] word_t;

    // one slice handled by the alu in a single clock
    typedef logic [`NIB_W-1:0] nibble_t;

    // position of the nibble being processed
    typedef logic [`NIB_IDX_W-1:0] nib_idx_t;

    // command codes as written to CTRL
    // values 5 to 7 are undefined
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND_OP = 3'd2,
        XOR_OP = 3'd3,
        RSHFT  = 3'd4
    } alu_cmd_t;

endpackage

`default_nettype wire

// ==== design/regmap_pkg.sv ====
// apb address, status register and apb slave state types
`default_nettype none

`include "serial_alu_defs.svh"

package regmap_pkg;

    typedef logic [`APB_AW-1:0] apb_addr_t;

    // status register contents
    typedef logic [1:0] status_t;

    // bit positions inside status_t
    localparam int STAT_BUSY  = 0;
    localparam int STAT_CARRY = 1;

    // bus phase taken by the slave in the previous cycle
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

`default_nettype wire

// ==== design/nibble_bus_if.sv ====
// interface for one nibble step between the sequencer and the 4-bit alu
`default_nettype none

interface nibble_bus_if import alu_types_pkg::*; ();

    // request side, driven by the sequencer
    alu_cmd_t cmd;
    nibble_t  d1;
    nibble_t  d2;
    logic     carry_in;

    // answer side, driven by the alu
    nibble_t  res;
    logic     carry_out;

    modport seq (
        output cmd, d1, d2, carry_in,
        input  res, carry_out
    );

    modport alu (
        input  cmd, d1, d2, carry_in,
        output res, carry_out
    );

endinterface

`default_nettype wire

// ==== design/nibble_alu.sv ====
// combinational 4-bit alu that computes one nibble of a serial operation
`default_nettype none

`include "serial_alu_defs.svh"

module nibble_alu import alu_types_pkg::*; (
    nibble_bus_if.alu bus
);

    // second adder input, inverted for subtraction
    nibble_t          addend;
    // nibble sum with its carry in the top bit
    logic [`NIB_W:0]  sum;

    // one adder serves both ADD and SUB
    always_comb begin
        if (bus.cmd == SUB) begin
            addend = ~bus.d2;
        end else begin
            addend = bus.d2;
        end
    end

    assign sum = {1'b0, bus.d1} + {1'b0, addend} + {{`NIB_W{1'b0}}, bus.carry_in};

    always_comb begin
        bus.res       = '0;
        bus.carry_out = 1'b0;
        case (bus.cmd)
            ADD, SUB: begin
                bus.res       = sum[`NIB_W-1:0];
                bus.carry_out = sum[`NIB_W];
            end
            AND_OP: begin
                bus.res = bus.d1 & bus.d2;
            end
            XOR_OP: begin
                bus.res = bus.d1 ^ bus.d2;
            end
            RSHFT: begin
                // shift-in bit comes from the next higher nibble
                bus.res = {bus.carry_in, bus.d1[`NIB_W-1:1]};
            end
            default: begin
                bus.res       = '0;
                bus.carry_out = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/nibble_sequencer.sv ====
// nibble counter, operand select, result insert and carry register of the serial alu
`default_nettype none

`include "serial_alu_defs.svh"

module nibble_sequencer import alu_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  alu_cmd_t  cmd,
    input  word_t     op_a,
    input  word_t     op_b,
    output logic      busy,
    output word_t     result,
    output logic      carry,
    nibble_bus_if.seq alu
);

    // highest nibble index, also the last value of the step count
    localparam nib_idx_t LAST_IDX = nib_idx_t'(`NIB_CNT - 1);

    // nibble currently on the bus
    nib_idx_t idx_q;
    // number of nibbles already done
    nib_idx_t step_q;

    // right shift walks from the msb nibble down to the lsb nibble
    logic     reverse;
    nib_idx_t idx_next;
    logic     carry_next;
    logic     last_step;

    assign reverse = (cmd == RSHFT);

    // operand nibble select
    assign alu.cmd      = cmd;
    assign alu.d1       = op_a[idx_q * `NIB_W +: `NIB_W];
    assign alu.d2       = op_b[idx_q * `NIB_W +: `NIB_W];
    assign alu.carry_in = carry;

    // index walks up for the arithmetic and bitwise commands
    always_comb begin
        if (reverse) begin
            idx_next = idx_q - 1'b1;
        end else begin
            idx_next = idx_q + 1'b1;
        end
    end

    // for a shift the dropped bit feeds the next lower nibble
    always_comb begin
        if (reverse) begin
            carry_next = alu.d1[0];
        end else begin
            carry_next = alu.carry_out;
        end
    end

    assign last_step = (step_q == LAST_IDX);

    // control state and carry
    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            idx_q  <= '0;
            step_q <= '0;
            carry  <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            step_q <= '0;
            if (reverse) begin
                idx_q <= LAST_IDX;
            end else begin
                idx_q <= '0;
            end
            // subtraction adds the inverted operand plus one
            carry <= (cmd == SUB);
        end else if (busy) begin
            idx_q  <= idx_next;
            step_q <= step_q + 1'b1;
            carry  <= carry_next;
            if (last_step) begin
                busy <= 1'b0;
            end
        end
    end

    // result nibble insert at the current index
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (busy) begin
            result[idx_q * `NIB_W +: `NIB_W] <= alu.res;
        end
    end

endmodule

`default_nettype wire

// ==== design/apb_alu_regs.sv ====
// apb slave with operand, control, status and result registers of the serial alu
`default_nettype none

`include "serial_alu_defs.svh"

module apb_alu_regs
    import alu_types_pkg::*;
    import regmap_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    output alu_cmd_t  cmd,
    output word_t     op_a,
    output word_t     op_b,
    input  logic      busy,
    input  word_t     result,
    input  logic      carry
);

    apb_state_t state_q;
    apb_state_t state_d;

    logic    xfer;
    logic    engine_busy;
    logic    rd_wait;
    logic    addr_known;
    logic    writable;
    logic    cmd_bad;
    logic    err;
    logic    wr_ok;
    word_t   rdata;
    status_t status;

    // an access phase counts only after a setup phase was taken
    assign xfer = psel && penable && (state_q != IDLE);

    // the start cycle already counts as busy
    assign engine_busy = busy || start;

    always_comb begin
        case (state_q)
            IDLE: begin
                state_d = (psel && !penable) ? SETUP : IDLE;
            end
            default: begin
                if (xfer && !pready) begin
                    state_d = ACCESS;
                end else if (psel && !penable) begin
                    state_d = SETUP;
                end else begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    // RESULT reads stall until the operation ends
    assign rd_wait = xfer && !pwrite && (paddr == `REG_RESULT) && engine_busy;
    assign pready  = !rd_wait;

    always_comb begin
        status             = '0;
        status[STAT_BUSY]  = engine_busy;
        status[STAT_CARRY] = carry;
    end

    // read mux and address decode
    always_comb begin
        addr_known = 1'b1;
        rdata      = '0;
        case (paddr)
            `REG_OP_A:   rdata = op_a;
            `REG_OP_B:   rdata = op_b;
            `REG_CTRL:   rdata = word_t'(cmd);
            `REG_STATUS: rdata = word_t'(status);
            `REG_RESULT: rdata = result;
            default:     addr_known = 1'b0;
        endcase
    end

    // only codes of the command enum may start an operation
    always_comb begin
        cmd_bad = 1'b1;
        if (pwdata[`WORD_W-1:$bits(alu_cmd_t)] == '0) begin
            case (pwdata[$bits(alu_cmd_t)-1:0])
                ADD, SUB, AND_OP, XOR_OP, RSHFT: cmd_bad = 1'b0;
                default:                         cmd_bad = 1'b1;
            endcase
        end
    end

    assign writable = (paddr == `REG_OP_A) || (paddr == `REG_OP_B) || (paddr == `REG_CTRL);

    assign err = !addr_known
        || (pwrite && writable && engine_busy)
        || (pwrite && (paddr == `REG_CTRL) && cmd_bad);

    assign wr_ok   = xfer && pwrite && !err;
    assign pslverr = xfer && pready && err;
    assign prdata  = (xfer && pready && !pwrite) ? rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            start   <= 1'b0;
            cmd     <= ADD;
            op_a    <= '0;
            op_b    <= '0;
        end else begin
            state_q <= state_d;
            start   <= wr_ok && (paddr == `REG_CTRL);
            if (wr_ok) begin
                case (paddr)
                    `REG_OP_A: op_a <= pwdata;
                    `REG_OP_B: op_b <= pwdata;
                    `REG_CTRL: cmd  <= alu_cmd_t'(pwdata[$bits(alu_cmd_t)-1:0]);
                    default:   ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/serial_alu_top.sv ====
// top level of the apb nibble-serial alu with register block, sequencer and alu
`default_nettype none

module serial_alu_top
    import alu_types_pkg::*;
    import regmap_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    // register block to sequencer
    logic     start;
    alu_cmd_t cmd;
    word_t    op_a;
    word_t    op_b;

    // sequencer back to register block
    logic     busy;
    word_t    result;
    logic     carry;

    nibble_bus_if nib_bus ();

    apb_alu_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .cmd     (cmd),
        .op_a    (op_a),
        .op_b    (op_b),
        .busy    (busy),
        .result  (result),
        .carry   (carry)
    );

    nibble_sequencer u_seq (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .cmd    (cmd),
        .op_a   (op_a),
        .op_b   (op_b),
        .busy   (busy),
        .result (result),
        .carry  (carry),
        .alu    (nib_bus.seq)
    );

    nibble_alu u_alu (
        .bus (nib_bus.alu)
    );

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
// testbench clock and synchronous reset source
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset covers the first rising edges, released away from them
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/serial_alu_tb.sv ====
// testbench top with apb tasks, stimulus and checking assertions of the serial alu
`default_nettype none

`include "serial_alu_defs.svh"

module serial_alu_tb import alu_types_pkg::*, regmap_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 40;
    localparam int RAND_PAIRS = 20;

    logic      clk;
    logic      rst;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    // expectations for the transfer in its access phase
    logic      check_on;
    logic      check_data;
    word_t     exp_data;
    logic      exp_err;

    // results of the last transfer
    word_t     rd_value;
    int        rd_waits;
    int        done_edge;

    int        edge_cnt;
    integer    seed;
    word_t     a;
    word_t     b;
    logic [`WORD_W:0] want;
    int        start_edge;
    int        polls;
    logic      exp_busy;

    clock_gen u_clk (.clk(clk), .rst(rst));

    serial_alu_top UUT (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    task automatic report_mismatch(input string name, input word_t exp_v, input word_t got);
        $display("Error at %0d ns: %s expected 0x%h, actual 0x%h", $time, name, exp_v, got);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    rd_data_chk: assert property (@(posedge clk) disable iff (rst)
        (check_on && check_data && psel && penable && pready) |-> (prdata == exp_data))
        else report_mismatch("prdata", exp_data, $sampled(prdata));

    err_chk: assert property (@(posedge clk) disable iff (rst)
        (check_on && psel && penable && pready) |-> (pslverr == exp_err))
        else report_mismatch("pslverr", word_t'(exp_err), word_t'($sampled(pslverr)));

    // {carry, result} from the word-level rules
    function automatic logic [`WORD_W:0] expected_op(input alu_cmd_t cmd, input word_t x,
                                                     input word_t y);
        logic [`WORD_W:0] r;
        case (cmd)
            ADD:     r = {1'b0, x} + {1'b0, y};
            SUB:     r = {1'b0, x} + {1'b0, ~y} + 33'd1;
            AND_OP:  r = {1'b0, x & y};
            XOR_OP:  r = {1'b0, x ^ y};
            default: r = {x[0], 1'b0, x[`WORD_W-1:1]};
        endcase
        return r;
    endfunction

    // setup phase, then access phase until pready
    task automatic apb_xfer(input apb_addr_t addr, input logic write, input word_t wdata,
                            input word_t exp_rd, input logic err);
        @(negedge clk);
        paddr    = addr;
        pwrite   = write;
        pwdata   = wdata;
        psel     = 1'b1;
        penable  = 1'b0;
        check_on = 1'b0;
        @(negedge clk);
        penable    = 1'b1;
        exp_data   = exp_rd;
        exp_err    = err;
        check_data = !write;
        check_on   = 1'b1;
        rd_waits   = 0;
        // pready is looked at mid cycle, away from both edges
        #1;
        while (!pready) begin
            rd_waits++;
            if (rd_waits > WAIT_LIMIT) begin
                $display("Timeout: no pready within %0d cycles at address %h", WAIT_LIMIT, addr);
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
            @(posedge clk);
            #1;
        end
        rd_value  = prdata;
        done_edge = edge_cnt + 1;
        @(posedge clk);
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data, input logic err);
        apb_xfer(addr, 1'b1, data, '0, err);
    endtask

    task automatic read_reg(input apb_addr_t addr, input word_t exp_rd, input logic err);
        apb_xfer(addr, 1'b0, '0, exp_rd, err);
    endtask

    // operands, command, stalled RESULT read right after start, final status
    task automatic run_op(input alu_cmd_t cmd, input word_t x, input word_t y);
        logic [`WORD_W:0] r;
        r = expected_op(cmd, x, y);
        write_reg(`REG_OP_A, x, 1'b0);
        write_reg(`REG_OP_B, y, 1'b0);
        write_reg(`REG_CTRL, word_t'(cmd), 1'b0);
        read_reg(`REG_RESULT, r[`WORD_W-1:0], 1'b0);
        assert (rd_waits == `NIB_CNT)
            else report_mismatch("RESULT wait cycles", `NIB_CNT, rd_waits);
        read_reg(`REG_STATUS, word_t'({r[`WORD_W], 1'b0}), 1'b0);
    endtask

    initial begin
        seed       = 32'h2dfb4f7d;
        edge_cnt   = 0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        check_on   = 1'b0;
        check_data = 1'b0;
        exp_data   = '0;
        exp_err    = 1'b0;
        polls      = 0;
        @(posedge clk);
        while (rst !== 1'b0) begin
            polls++;
            if (polls > WAIT_LIMIT) begin
                $display("Timeout: reset was never released");
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
            @(posedge clk);
        end

        read_reg(`REG_STATUS, '0, 1'b0);
        read_reg(`REG_RESULT, '0, 1'b0);

        // carry chains across nibbles, then a borrow
        run_op(ADD, 32'hefffffff, 32'h00000001);
        run_op(ADD, 32'hffff0fff, 32'h00000002);
        run_op(SUB, 32'h00000005, 32'h00000007);
        for (int i = 0; i < RAND_PAIRS; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_op(ADD, a, b);
            run_op(SUB, a, b);
        end
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_op(AND_OP, a, b);
            run_op(XOR_OP, a, b);
            run_op(RSHFT, a, b);
        end

        // busy is seen at the edges C+2 to C+9 after the CTRL write at edge C
        a = $random(seed);
        b = $random(seed);
        write_reg(`REG_OP_A, a, 1'b0);
        write_reg(`REG_OP_B, b, 1'b0);
        write_reg(`REG_CTRL, word_t'(AND_OP), 1'b0);
        start_edge = done_edge;
        polls      = 0;
        do begin
            exp_busy = (done_edge + 2 - start_edge <= `NIB_CNT + 1);
            read_reg(`REG_STATUS, word_t'(exp_busy), 1'b0);
            polls++;
            if (polls > WAIT_LIMIT) begin
                $display("Timeout: STATUS kept showing busy");
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
        end while (rd_value[0]);
        read_reg(`REG_RESULT, a & b, 1'b0);

        // writes while busy are refused and the running operation keeps its operands
        a    = $random(seed);
        b    = $random(seed);
        want = expected_op(ADD, a, b);
        write_reg(`REG_OP_A, a, 1'b0);
        write_reg(`REG_OP_B, b, 1'b0);
        write_reg(`REG_CTRL, word_t'(ADD), 1'b0);
        write_reg(`REG_OP_A, ~a, 1'b1);
        write_reg(`REG_CTRL, word_t'(SUB), 1'b1);
        read_reg(`REG_RESULT, want[`WORD_W-1:0], 1'b0);
        read_reg(`REG_OP_A, a, 1'b0);
        write_reg(`REG_CTRL, word_t'(XOR_OP), 1'b0);
        read_reg(`REG_RESULT, a ^ b, 1'b0);

        // undefined commands must not start, so STATUS stays idle
        write_reg(`REG_CTRL, 32'h00000005, 1'b1);
        write_reg(`REG_CTRL, 32'h00000100, 1'b1);
        read_reg(`REG_STATUS, '0, 1'b0);

        // unknown addresses
        read_reg(5'h14, '0, 1'b1);
        read_reg(5'h1c, '0, 1'b1);
        write_reg(5'h18, 32'hffffffff, 1'b1);

        @(negedge clk);
        psel     = 1'b0;
        penable  = 1'b0;
        check_on = 1'b0;
        @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
// packages and interface before the modules that import them
+incdir+design
design/alu_types_pkg.sv
design/regmap_pkg.sv
design/nibble_bus_if.sv
design/nibble_alu.sv
design/nibble_sequencer.sv
design/apb_alu_regs.sv
design/serial_alu_top.sv
// testbench
sim/clock_gen.sv
sim/serial_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the serial alu testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=serial_alu_tb

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
fi
exit "$status"
